/* Makefile */
VERILATOR ?= verilator
TOP       := tb_rx_edit
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* edit_job_regs.sv */
`timescale 1ns/1ps

module edit_job_regs #(
	parameter int DATA_BYTES = 32,
	parameter int HDR_BYTES  = 8
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                msg_nempty,
	input  edit_pkg::edit_msg_t msg_rdata,
	input  logic                pkt_nempty,
	input  logic                job_done,
	output logic                msg_ren,
	output edit_pkg::edit_job_t job,
	output logic                job_start
);

	logic                busy;
	edit_pkg::edit_cmd_t cmd_c;
	edit_pkg::byte_len_t out_len_c;
	logic [16:0]         in_sum;
	logic [16:0]         out_sum;

	assign msg_ren = !busy && msg_nempty && pkt_nempty;

	// decode the command and work out the lengths of the packet being popped.
	always_comb begin
		case (msg_rdata.cmd)
			edit_pkg::cmd_strip, edit_pkg::cmd_prepend, edit_pkg::cmd_drop:
				cmd_c = msg_rdata.cmd;
			default:
				cmd_c = edit_pkg::cmd_pass;  // code 0 and unknown codes copy.
		endcase
		case (cmd_c)
			edit_pkg::cmd_strip:   out_len_c = msg_rdata.plen - edit_pkg::byte_len_t'(HDR_BYTES);
			edit_pkg::cmd_prepend: out_len_c = msg_rdata.plen + edit_pkg::byte_len_t'(HDR_BYTES);
			edit_pkg::cmd_drop:    out_len_c = '0;
			default:               out_len_c = msg_rdata.plen;
		endcase
		in_sum  = {1'b0, msg_rdata.plen} + 17'(DATA_BYTES - 1);
		out_sum = {1'b0, out_len_c} + 17'(DATA_BYTES - 1);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy      <= 1'b0;
			job_start <= 1'b0;
		end else begin
			job_start <= msg_ren;
			if (msg_ren) begin
				busy <= 1'b1;
			end else if (job_done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (msg_ren) begin
			job.cmd       <= cmd_c;
			job.out_len   <= out_len_c;
			job.in_words  <= edit_pkg::word_cnt_t'(in_sum / DATA_BYTES);
			job.out_words <= edit_pkg::word_cnt_t'(out_sum / DATA_BYTES);
			job.flow_id   <= msg_rdata.flow_id;
			job.chn_id    <= msg_rdata.chn_id;
		end
	end

endmodule

/* edit_out_framer.sv */
`timescale 1ns/1ps

module edit_out_framer #(
	parameter int DATA_BYTES = 32
) (
	input  logic                    clk,
	input  logic                    rst,
	input  edit_pkg::edit_job_t     job,
	input  logic                    word_vld,
	input  logic [DATA_BYTES*8-1:0] word,
	output logic                    out_vld,
	output logic [DATA_BYTES*8-1:0] out_dat,
	output edit_pkg::out_msg_t      out_msg
);

	edit_pkg::word_cnt_t cnt;  // output word index within the packet.
	edit_pkg::edit_job_t job_q;
	edit_pkg::edit_job_t cur;
	edit_pkg::byte_len_t span;
	logic                sop;
	logic                eop;
	logic [7:0]          mty;

	// the job register may already hold the next packet after sop.
	always_comb begin
		cur  = (cnt == '0) ? job : job_q;
		sop  = word_vld && cnt == '0;
		eop  = word_vld && cnt == edit_pkg::word_cnt_t'(cur.out_words - 1'b1);
		span = edit_pkg::byte_len_t'(cur.out_words * DATA_BYTES);
		mty  = eop ? 8'(span - cur.out_len) : 8'd0;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt     <= '0;
			out_vld <= 1'b0;
			out_msg <= '0;
		end else begin
			out_vld <= word_vld;
			if (word_vld) begin
				cnt <= eop ? '0 : cnt + 1'b1;
			end
			out_msg.flow_id <= cur.flow_id;
			out_msg.chn_id  <= cur.chn_id;
			out_msg.len     <= cur.out_len;
			out_msg.mty     <= mty;
			out_msg.sop     <= sop;
			out_msg.eop     <= eop;
		end
	end

	always_ff @(posedge clk) begin
		if (sop) begin
			job_q <= job;
		end
		if (word_vld) begin
			out_dat <= word;
		end
	end

endmodule

/* edit_pkg.sv */
package edit_pkg;

	// ------------------------------------------------------------------------
	// edit commands, codes as carried in the command FIFO word
	// ------------------------------------------------------------------------
	typedef enum logic [3:0] {
		cmd_none    = 4'd0,  // unused code, handled like pass.
		cmd_strip   = 4'd1,
		cmd_prepend = 4'd2,
		cmd_pass    = 4'd3,
		cmd_drop    = 4'd4
	} edit_cmd_t;

	typedef logic [15:0] byte_len_t;  // packet length in bytes.
	typedef logic [10:0] word_cnt_t;  // data words in one packet.
	typedef logic [15:0] flow_id_t;
	typedef logic [3:0]  chn_id_t;

	// ------------------------------------------------------------------------
	// structs passed between the blocks
	// ------------------------------------------------------------------------
	typedef struct packed {
		edit_cmd_t cmd;
		byte_len_t plen;
		flow_id_t  flow_id;
		chn_id_t   chn_id;
	} edit_msg_t;

	typedef struct packed {
		edit_cmd_t cmd;
		byte_len_t out_len;
		word_cnt_t in_words;
		word_cnt_t out_words;
		flow_id_t  flow_id;
		chn_id_t   chn_id;
	} edit_job_t;

	typedef struct packed {
		logic vld;
		logic load_hdr;  // header word goes into the carry.
		logic load_pkt;
		logic emit;
		logic first;     // first packet word of the job.
		logic flush;     // emit the carry alone.
	} edit_step_t;

	typedef struct packed {
		flow_id_t  flow_id;
		chn_id_t   chn_id;
		byte_len_t len;
		logic [7:0] mty;
		logic       sop;
		logic       eop;
	} out_msg_t;

endpackage

/* edit_read_ctrl.sv */
`timescale 1ns/1ps

module edit_read_ctrl (
	input  logic                 clk,
	input  logic                 rst,
	input  edit_pkg::edit_job_t  job,
	input  logic                 job_start,
	input  logic                 out_rdy,
	input  logic                 pkt_nempty,
	input  logic                 hdr_nempty,
	output logic                 pkt_ren,
	output logic                 hdr_ren,
	output logic                 job_done,
	output edit_pkg::edit_step_t step
);

	typedef enum logic [2:0] {
		st_idle,
		st_header,
		st_body,
		st_flush,
		st_drop
	} state_t;

	state_t              state;
	edit_pkg::word_cnt_t rd_cnt;    // packet words read so far.
	edit_pkg::word_cnt_t emit_cnt;  // output words issued so far.
	edit_pkg::word_cnt_t emit_nxt;
	logic                hdr_go;
	logic                pkt_go;
	logic                flush_go;
	logic                first_rd;
	logic                last_rd;
	logic                emit_pkt;
	logic                need_flush;

	// ------------------------------------------------------------------------
	// step decode
	// ------------------------------------------------------------------------
	always_comb begin
		hdr_go   = state == st_header && out_rdy && hdr_nempty;
		pkt_go   = (state == st_body && out_rdy && pkt_nempty) ||
			(state == st_drop && pkt_nempty);  // a dropped packet drains regardless.
		flush_go = state == st_flush && out_rdy;
		first_rd = rd_cnt == '0;
		last_rd  = rd_cnt == edit_pkg::word_cnt_t'(job.in_words - 1'b1);
		// the first strip word only fills the carry.
		emit_pkt = state == st_body && !(job.cmd == edit_pkg::cmd_strip && first_rd);
		emit_nxt = emit_cnt + edit_pkg::word_cnt_t'(emit_pkt);
		need_flush = job.out_words > emit_nxt;
	end

	assign pkt_ren  = pkt_go;
	assign hdr_ren  = hdr_go;
	assign job_done = (pkt_go && last_rd && !(state == st_body && need_flush)) || flush_go;

	always_comb begin
		step          = '0;
		step.vld      = hdr_go || pkt_go || flush_go;
		step.load_hdr = hdr_go;
		step.load_pkt = pkt_go;
		step.emit     = (pkt_go && emit_pkt) || flush_go;
		step.first    = pkt_go && first_rd;
		step.flush    = flush_go;
	end

	// ------------------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= st_idle;
			rd_cnt   <= '0;
			emit_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (job_start) begin
						rd_cnt   <= '0;
						emit_cnt <= '0;
						case (job.cmd)
							edit_pkg::cmd_prepend: state <= st_header;
							edit_pkg::cmd_drop:    state <= st_drop;
							default:               state <= st_body;
						endcase
					end
				end
				st_header: begin
					if (hdr_go) begin
						state <= st_body;
					end
				end
				st_body: begin
					if (pkt_go) begin
						rd_cnt   <= rd_cnt + 1'b1;
						emit_cnt <= emit_nxt;
						if (last_rd) begin
							state <= need_flush ? st_flush : st_idle;
						end
					end
				end
				st_flush: begin
					if (flush_go) begin
						state <= st_idle;
					end
				end
				st_drop: begin
					if (pkt_go) begin
						rd_cnt <= rd_cnt + 1'b1;
						if (last_rd) begin
							state <= st_idle;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* edit_shifter.sv */
`timescale 1ns/1ps

module edit_shifter #(
	parameter int DATA_BYTES = 32,
	parameter int HDR_BYTES  = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  edit_pkg::edit_cmd_t     cmd,
	input  edit_pkg::edit_step_t    step,
	input  logic [DATA_BYTES*8-1:0] pkt_rdata,
	input  logic [DATA_BYTES*8-1:0] hdr_rdata,
	output logic                    word_vld,
	output logic [DATA_BYTES*8-1:0] word
);

	localparam int W  = DATA_BYTES * 8;
	localparam int HW = HDR_BYTES * 8;

	// the carry is kept left aligned, byte 0 at the top, zeros below it.
	logic [W-1:0] carry;
	logic [W-1:0] carry_use;
	logic [W-1:0] carry_nxt;
	logic [W-1:0] merged;

	always_comb begin
		// a new packet never sees the carry of the one before.
		carry_use = (step.first && cmd != edit_pkg::cmd_prepend) ? '0 : carry;
		case (cmd)
			edit_pkg::cmd_prepend: begin
				merged    = step.flush ? carry_use : carry_use | (pkt_rdata >> HW);
				carry_nxt = pkt_rdata << (W - HW);  // last HDR_BYTES bytes.
			end
			edit_pkg::cmd_strip: begin
				merged    = step.flush ? carry_use : carry_use | (pkt_rdata >> (W - HW));
				carry_nxt = pkt_rdata << HW;  // everything after the header.
			end
			default: begin
				merged    = pkt_rdata;
				carry_nxt = pkt_rdata;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_vld <= 1'b0;
		end else begin
			word_vld <= step.vld && step.emit;
		end
	end

	always_ff @(posedge clk) begin
		if (step.load_hdr) begin
			carry <= {hdr_rdata[W-1 -: HW], {(W - HW){1'b0}}};
		end else if (step.load_pkt) begin
			carry <= carry_nxt;
		end
		if (step.vld && step.emit) begin
			word <= merged;
		end
	end

endmodule

/* rx_edit.sv */
`timescale 1ns/1ps

module rx_edit #(
	parameter int DATA_BYTES = 32,
	parameter int HDR_BYTES  = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	// command FIFO
	input  logic                    msg_nempty,
	output logic                    msg_ren,
	input  edit_pkg::edit_msg_t     msg_rdata,
	// packet FIFO
	input  logic                    pkt_nempty,
	output logic                    pkt_ren,
	input  logic [DATA_BYTES*8-1:0] pkt_rdata,
	// header FIFO
	input  logic                    hdr_nempty,
	output logic                    hdr_ren,
	input  logic [DATA_BYTES*8-1:0] hdr_rdata,
	// edited packet stream
	input  logic                    out_rdy,
	output logic                    out_vld,
	output logic [DATA_BYTES*8-1:0] out_dat,
	output edit_pkg::out_msg_t      out_msg
);

	edit_pkg::edit_job_t     job;
	edit_pkg::edit_step_t    step;
	logic                    job_start;
	logic                    job_done;
	logic                    word_vld;
	logic [DATA_BYTES*8-1:0] word;

	edit_job_regs #(
		.DATA_BYTES(DATA_BYTES),
		.HDR_BYTES (HDR_BYTES)
	) u_job_regs (
		.clk       (clk),
		.rst       (rst),
		.msg_nempty(msg_nempty),
		.msg_rdata (msg_rdata),
		.pkt_nempty(pkt_nempty),
		.job_done  (job_done),
		.msg_ren   (msg_ren),
		.job       (job),
		.job_start (job_start)
	);

	edit_read_ctrl u_read_ctrl (
		.clk       (clk),
		.rst       (rst),
		.job       (job),
		.job_start (job_start),
		.out_rdy   (out_rdy),
		.pkt_nempty(pkt_nempty),
		.hdr_nempty(hdr_nempty),
		.pkt_ren   (pkt_ren),
		.hdr_ren   (hdr_ren),
		.job_done  (job_done),
		.step      (step)
	);

	edit_shifter #(
		.DATA_BYTES(DATA_BYTES),
		.HDR_BYTES (HDR_BYTES)
	) u_shifter (
		.clk      (clk),
		.rst      (rst),
		.cmd      (job.cmd),
		.step     (step),
		.pkt_rdata(pkt_rdata),
		.hdr_rdata(hdr_rdata),
		.word_vld (word_vld),
		.word     (word)
	);

	edit_out_framer #(
		.DATA_BYTES(DATA_BYTES)
	) u_out_framer (
		.clk     (clk),
		.rst     (rst),
		.job     (job),
		.word_vld(word_vld),
		.word    (word),
		.out_vld (out_vld),
		.out_dat (out_dat),
		.out_msg (out_msg)
	);

endmodule

/* rx_edit_assertions.sv */
`timescale 1ns/1ps

module rx_edit_assertions (
	input logic               clk,
	input logic               rst,
	input logic               msg_ren,
	input logic               pkt_ren,
	input logic               pkt_nempty,
	input logic               hdr_ren,
	input logic               hdr_nempty,
	input logic               job_done,
	input logic               out_vld,
	input edit_pkg::out_msg_t out_msg
);

	logic in_job;  // a command was popped and its packet is not finished yet.

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_job <= 1'b0;
		end else if (msg_ren) begin
			in_job <= 1'b1;
		end else if (job_done) begin
			in_job <= 1'b0;
		end
	end

	pkt_ren_needs_data: assert property (@(posedge clk) disable iff (rst)
		pkt_ren |-> pkt_nempty)
		else $error("pkt_ren while the packet FIFO is empty");

	hdr_ren_needs_data: assert property (@(posedge clk) disable iff (rst)
		hdr_ren |-> hdr_nempty)
		else $error("hdr_ren while the header FIFO is empty");

	markers_need_vld: assert property (@(posedge clk) disable iff (rst)
		(out_msg.sop || out_msg.eop) |-> out_vld)
		else $error("sop or eop set on a cycle without out_vld");

	one_job_at_a_time: assert property (@(posedge clk) disable iff (rst)
		msg_ren |-> !in_job)
		else $error("msg_ren while a packet is still in progress");

endmodule

/* rx_edit_vectors.txt */
# cmd plen flow chn base header exp_len
# cmd hex (3 pass, 0 pass, 1 strip, 2 prepend, 4 drop), plen and exp_len decimal, rest hex
3  32 0101 1 00 0000000000000000  32
3  64 0102 2 40 0000000000000000  64
3  45 0103 3 a0 0000000000000000  45
3   1 0104 4 f0 0000000000000000   1
0  70 0105 5 11 0000000000000000  70
1  40 0201 6 20 0000000000000000  32
1  50 0202 7 30 0000000000000000  42
1  20 0203 8 50 0000000000000000  12
1  96 0204 9 60 0000000000000000  88
1  72 0205 a 70 0000000000000000  64
2  10 0301 b 80 c0c1c2c3c4c5c6c7  18
2  24 0302 c 90 d0d1d2d3d4d5d6d7  32
2  30 0303 d a0 e0e1e2e3e4e5e6e7  38
2  64 0304 e b0 a5a4a3a2a1a09f9e  72
4  50 0401 f c0 0000000000000000   0
3  33 0402 0 d0 0000000000000000  33
4 128 0403 1 e0 0000000000000000   0
2  90 0404 2 f0 1122334455667788  98
1 105 0405 3 05 0000000000000000  97
4  17 0406 4 07 0000000000000000   0
3 130 0407 5 09 0000000000000000 130

/* sim.f */
edit_pkg.sv
edit_job_regs.sv
edit_read_ctrl.sv
edit_shifter.sv
edit_out_framer.sv
rx_edit.sv
rx_edit_assertions.sv
tb_clock.sv
tb_rx_edit.sv

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

endmodule

/* tb_rx_edit.sv */
`timescale 1ns/1ps

module tb_rx_edit;

	localparam int DATA_BYTES = 32;
	localparam int HDR_BYTES  = 8;
	localparam int W          = DATA_BYTES * 8;

	logic                clk;
	logic                rst;
	logic                msg_nempty;
	logic                msg_ren;
	edit_pkg::edit_msg_t msg_rdata;
	logic                pkt_nempty;
	logic                pkt_ren;
	logic [W-1:0]        pkt_rdata;
	logic                hdr_nempty;
	logic                hdr_ren;
	logic [W-1:0]        hdr_rdata;
	logic                out_rdy;
	logic                out_vld;
	logic [W-1:0]        out_dat;
	edit_pkg::out_msg_t  out_msg;

	edit_pkg::edit_msg_t msg_q[$];  // the three FIFO models.
	logic [W-1:0]        pkt_q[$];
	logic [W-1:0]        hdr_q[$];
	logic [W-1:0]        exp_dat_q[$];
	logic [W-1:0]        exp_mask_q[$];
	edit_pkg::out_msg_t  exp_msg_q[$];

	logic msg_ren_s = 1'b0;  // read enables as seen at the last rising edge.
	logic pkt_ren_s = 1'b0;
	logic hdr_ren_s = 1'b0;
	logic fifo_open;
	int   cycle_cnt = 0;
	int   cycle_limit = 0;
	int   in_words_total = 0;
	int   prepend_cnt = 0;
	int   msg_pops = 0;
	int   pkt_pops = 0;
	int   hdr_pops = 0;

	tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

	rx_edit #(
		.DATA_BYTES(DATA_BYTES),
		.HDR_BYTES (HDR_BYTES)
	) uut (
		.clk       (clk),
		.rst       (rst),
		.msg_nempty(msg_nempty),
		.msg_ren   (msg_ren),
		.msg_rdata (msg_rdata),
		.pkt_nempty(pkt_nempty),
		.pkt_ren   (pkt_ren),
		.pkt_rdata (pkt_rdata),
		.hdr_nempty(hdr_nempty),
		.hdr_ren   (hdr_ren),
		.hdr_rdata (hdr_rdata),
		.out_rdy   (out_rdy),
		.out_vld   (out_vld),
		.out_dat   (out_dat),
		.out_msg   (out_msg)
	);

	bind rx_edit rx_edit_assertions u_assertions (
		.clk       (clk),
		.rst       (rst),
		.msg_ren   (msg_ren),
		.pkt_ren   (pkt_ren),
		.pkt_nempty(pkt_nempty),
		.hdr_ren   (hdr_ren),
		.hdr_nempty(hdr_nempty),
		.job_done  (job_done),
		.out_vld   (out_vld),
		.out_msg   (out_msg)
	);

	// ------------------------------------------------------------------------
	// checking helpers
	// ------------------------------------------------------------------------
	task automatic check_value(input string name, input logic [W-1:0] got,
			input logic [W-1:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %0h, expected %0h", name, got, exp);
			$display("Testbench failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge clk) begin
		msg_ren_s <= msg_ren;
		pkt_ren_s <= pkt_ren;
		hdr_ren_s <= hdr_ren;
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles with %0d output words never seen",
				cycle_cnt, exp_dat_q.size());
			$display("Testbench failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// ------------------------------------------------------------------------
	// stimulus and expected stream from the vector file
	// ------------------------------------------------------------------------
	task automatic push_packet(input int plen, input logic [7:0] base);
		logic [W-1:0] data;
		int           idx;
		for (int w = 0; w < (plen + DATA_BYTES - 1) / DATA_BYTES; w++) begin
			data = '0;
			for (int b = 0; b < DATA_BYTES; b++) begin
				idx = w * DATA_BYTES + b;
				data[W-1-8*b -: 8] = (idx < plen) ? 8'(base + idx) : 8'hcc;  // pad past the end.
			end
			pkt_q.push_back(data);
		end
	endtask

	task automatic expect_packet(input logic [3:0] cmd, input int plen, input logic [15:0] flow,
			input logic [3:0] chn, input logic [7:0] base, input logic [HDR_BYTES*8-1:0] hdr,
			input int exp_len);
		logic [7:0]         bytes[$];
		logic [W-1:0]       data;
		logic [W-1:0]       mask;
		edit_pkg::out_msg_t m;
		int                 nw;
		int                 idx;
		if (cmd == edit_pkg::cmd_prepend) begin
			for (int i = 0; i < HDR_BYTES; i++) begin
				bytes.push_back(hdr[HDR_BYTES*8-1-8*i -: 8]);
			end
		end
		if (cmd != edit_pkg::cmd_drop) begin
			for (int i = (cmd == edit_pkg::cmd_strip) ? HDR_BYTES : 0; i < plen; i++) begin
				bytes.push_back(8'(base + i));
			end
		end
		check_value("expected length", W'(bytes.size()), W'(exp_len));
		nw = (bytes.size() + DATA_BYTES - 1) / DATA_BYTES;
		for (int w = 0; w < nw; w++) begin
			data = '0;
			mask = '0;
			for (int b = 0; b < DATA_BYTES; b++) begin
				idx = w * DATA_BYTES + b;
				if (idx < bytes.size()) begin
					data[W-1-8*b -: 8] = bytes[idx];
					mask[W-1-8*b -: 8] = 8'hff;
				end
			end
			m.flow_id = flow;
			m.chn_id  = chn;
			m.len     = 16'(bytes.size());
			m.sop     = w == 0;
			m.eop     = w == nw - 1;
			m.mty     = m.eop ? 8'(nw * DATA_BYTES - bytes.size()) : 8'd0;
			exp_dat_q.push_back(data);
			exp_mask_q.push_back(mask);
			exp_msg_q.push_back(m);
		end
	endtask

	task automatic load_vectors();
		int                     fd;
		int                     n;
		string                  line;
		logic [3:0]             cmd;
		int                     plen;
		logic [15:0]            flow;
		logic [3:0]             chn;
		logic [7:0]             base;
		logic [HDR_BYTES*8-1:0] hdr;
		int                     exp_len;
		edit_pkg::edit_msg_t    m;
		fd = $fopen("rx_edit_vectors.txt", "r");
		if (fd == 0) begin
			report_error("cannot open rx_edit_vectors.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %d %h %h %h %h %d", cmd, plen, flow, chn, base, hdr,
						exp_len);
					if (n != 7) begin
						report_error({"unreadable vector line: ", line});
					end else begin
						m.cmd     = edit_pkg::edit_cmd_t'(cmd);
						m.plen    = 16'(plen);
						m.flow_id = flow;
						m.chn_id  = chn;
						msg_q.push_back(m);
						push_packet(plen, base);
						if (cmd == edit_pkg::cmd_prepend) begin
							hdr_q.push_back({hdr, {(DATA_BYTES - HDR_BYTES){8'hee}}});
							prepend_cnt++;
						end
						in_words_total += (plen + DATA_BYTES - 1) / DATA_BYTES;
						expect_packet(cmd, plen, flow, chn, base, hdr, exp_len);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ------------------------------------------------------------------------
	// one clock cycle of FIFO, output and drive work on the falling edge
	// ------------------------------------------------------------------------
	task automatic run_cycle();
		logic [W-1:0]       mask;
		logic [W-1:0]       data;
		edit_pkg::out_msg_t m;
		@(negedge clk);
		if (msg_ren_s) begin
			void'(msg_q.pop_front());
			msg_pops++;
		end
		if (pkt_ren_s) begin
			void'(pkt_q.pop_front());
			pkt_pops++;
		end
		if (hdr_ren_s) begin
			void'(hdr_q.pop_front());
			hdr_pops++;
		end
		if (msg_pops == 0) begin
			check_value("out_vld", W'(out_vld), W'(0));  // nothing may leave before a command.
		end
		if (out_vld && exp_dat_q.size() == 0) begin
			report_error("an output word arrived that no packet accounts for");
		end else if (out_vld) begin
			mask = exp_mask_q.pop_front();
			data = exp_dat_q.pop_front();
			m    = exp_msg_q.pop_front();
			check_value("out_dat", out_dat & mask, data & mask);
			check_value("out_msg.sop", W'(out_msg.sop), W'(m.sop));
			check_value("out_msg.eop", W'(out_msg.eop), W'(m.eop));
			check_value("out_msg.mty", W'(out_msg.mty), W'(m.mty));
			check_value("out_msg.len", W'(out_msg.len), W'(m.len));
			check_value("out_msg.flow_id", W'(out_msg.flow_id), W'(m.flow_id));
			check_value("out_msg.chn_id", W'(out_msg.chn_id), W'(m.chn_id));
		end
		msg_nempty = fifo_open && msg_q.size() > 0;
		msg_rdata  = msg_nempty ? msg_q[0] : '0;
		pkt_nempty = fifo_open && pkt_q.size() > 0;
		pkt_rdata  = pkt_nempty ? pkt_q[0] : '0;
		hdr_nempty = fifo_open && hdr_q.size() > 0;
		hdr_rdata  = hdr_nempty ? hdr_q[0] : '0;
		out_rdy    = ($urandom % 4) != 0;  // low about a quarter of the time.
	endtask

	initial begin
		void'($urandom(6740));
		rst        = 1'b1;
		msg_nempty = 1'b0;
		msg_rdata  = '0;
		pkt_nempty = 1'b0;
		pkt_rdata  = '0;
		hdr_nempty = 1'b0;
		hdr_rdata  = '0;
		out_rdy    = 1'b0;
		fifo_open  = 1'b0;
		load_vectors();
		cycle_limit = 8 * in_words_total + 200;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (10) run_cycle();  // FIFOs still empty, the DUT has to stay quiet.
		fifo_open = 1'b1;
		while (msg_q.size() > 0 || pkt_q.size() > 0 || exp_dat_q.size() > 0) begin
			run_cycle();
		end
		repeat (20) run_cycle();  // late words would show up here.
		check_value("hdr FIFO pops", W'(hdr_pops), W'(prepend_cnt));
		check_value("pkt FIFO pops", W'(pkt_pops), W'(in_words_total));
		$display("Testbench passed");
		$finish;
	end

endmodule
